// ==== iob_wb_macros.svh ====
`ifndef IOB_WB_MACROS_SVH
`define IOB_WB_MACROS_SVH

////////////////////////////////////////
// Bus widths
////////////////////////////////////////

`define IOB_WB_ADDR_W 32    // Byte address.
`define IOB_WB_DATA_W 32    // Strobe width is DATA_W/8.

////////////////////////////////////////
// Sizes and latency
////////////////////////////////////////

`define IOB_WB_CMD_DEPTH 4  // Command queue entries.

// Word RAM uses address bits 9 down to 2.
`define IOB_WB_RAM_WORDS 256

`define IOB_WB_WAIT 1       // Wait states before ack.

`endif

// ==== iob_wb_pkg.sv ====
`include "iob_wb_macros.svh"

package iob_wb_pkg;

   // IOb request, a zero wstrb marks a read.
   typedef struct packed {
      logic [`IOB_WB_ADDR_W-1:0]   addr;
      logic [`IOB_WB_DATA_W-1:0]   wdata;
      logic [`IOB_WB_DATA_W/8-1:0] wstrb;
   } iob_req_t;

   typedef struct packed {
      logic                      rvalid;
      logic [`IOB_WB_DATA_W-1:0] rdata;
      logic                      ready;
   } iob_rsp_t;

   // Wishbone master outputs.
   typedef struct packed {
      logic [`IOB_WB_ADDR_W-1:0]   addr;
      logic [`IOB_WB_DATA_W/8-1:0] sel;
      logic                        we;
      logic                        cyc;
      logic                        stb;
      logic [`IOB_WB_DATA_W-1:0]   data;
   } wb_req_t;

   typedef struct packed {
      logic                      ack;
      logic [`IOB_WB_DATA_W-1:0] data;
   } wb_rsp_t;

endpackage

// ==== iob_cmd_issuer.sv ====
`timescale 1ns/1ps

`include "iob_wb_macros.svh"

module iob_cmd_issuer (
   input  logic                 clk_i,
   input  logic                 reset_i,
   // External command strobe.
   input  logic                 cmd_valid_i,
   input  iob_wb_pkg::iob_req_t cmd_i,
   // IOb request port.
   input  logic                 iob_ready_i,
   output logic                 iob_avalid_o,
   output iob_wb_pkg::iob_req_t iob_req_o,
   output logic                 overflow_o
);
   import iob_wb_pkg::*;

   localparam int DEPTH = `IOB_WB_CMD_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   iob_req_t         queue_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             overflow_q;
   logic             full;
   logic             empty;
   logic             push;
   logic             pop;

   assign full  = (count_q == CNT_W'(DEPTH));
   assign empty = (count_q == '0);
   assign push  = cmd_valid_i && !full;
   assign pop   = !empty && iob_ready_i;  // Issue and pop together.

   assign iob_avalid_o = pop;
   assign iob_req_o    = queue_q[rd_ptr_q];
   assign overflow_o   = overflow_q;

   ////////////////////////////////////////
   // Queue control
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         overflow_q <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
         if (cmd_valid_i && full) begin
            overflow_q <= 1'b1;  // Sticky until reset.
         end
      end
   end

   // Entry storage.
   always_ff @(posedge clk_i) begin
      if (push) begin
         queue_q[wr_ptr_q] <= cmd_i;
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Bridge turns busy once a request is accepted.
   avalid_handshake_a : assert property (
      @(posedge clk_i) disable iff (reset_i)
      iob_avalid_o |=> !iob_ready_i
   ) else $error("ready still high after a request was accepted");

endmodule

// ==== iob_iob2wishbone.sv ====
`timescale 1ns/1ps

`include "iob_wb_macros.svh"

module iob_iob2wishbone (
   input  logic                 clk_i,
   input  logic                 reset_i,
   // IOb interface.
   input  logic                 iob_avalid_i,
   input  iob_wb_pkg::iob_req_t iob_req_i,
   output iob_wb_pkg::iob_rsp_t iob_rsp_o,
   // Wishbone interface.
   output iob_wb_pkg::wb_req_t  wb_req_o,
   input  iob_wb_pkg::wb_rsp_t  wb_rsp_i
);
   import iob_wb_pkg::*;

   localparam int DATA_W = `IOB_WB_DATA_W;
   localparam int STRB_W = DATA_W / 8;
   localparam int OFF_W  = $clog2(STRB_W);

   // Full-word read mask.
   localparam logic [STRB_W:0] RB_MASK = {1'b0, {STRB_W{1'b1}}};

   wb_req_t           new_req;
   wb_req_t           held_q;
   logic              ack_q;
   logic [DATA_W-1:0] rdata_q;

   ////////////////////////////////////////
   // Request path
   ////////////////////////////////////////

   always_comb begin
      new_req.addr = iob_req_i.addr;
      new_req.data = iob_req_i.wdata;
      new_req.we   = |iob_req_i.wstrb;
      new_req.sel  = new_req.we ? iob_req_i.wstrb :
                     STRB_W'(RB_MASK << iob_req_i.addr[OFF_W-1:0]);
      new_req.cyc  = 1'b1;
      new_req.stb  = 1'b1;
   end

   // New request passes through, the held copy covers the rest of the cycle.
   assign wb_req_o = iob_avalid_i ? new_req : held_q;

   always_ff @(posedge clk_i) begin
      if (reset_i || wb_rsp_i.ack) begin
         held_q.cyc <= 1'b0;
         held_q.stb <= 1'b0;
      end else if (iob_avalid_i) begin
         held_q.cyc <= 1'b1;
         held_q.stb <= 1'b1;
      end
      if (iob_avalid_i) begin
         held_q.addr <= new_req.addr;
         held_q.sel  <= new_req.sel;
         held_q.we   <= new_req.we;
         held_q.data <= new_req.data;
      end
   end

   ////////////////////////////////////////
   // Response path
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= wb_rsp_i.ack;
      end
      rdata_q <= wb_rsp_i.data;
   end

   always_comb begin
      iob_rsp_o.rvalid = ack_q & ~held_q.we;  // Reads only.
      iob_rsp_o.rdata  = wb_rsp_i.ack ? wb_rsp_i.data : rdata_q;
      iob_rsp_o.ready  = ~held_q.cyc | ack_q;
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   ack_needs_cyc_a : assert property (
      @(posedge clk_i) disable iff (reset_i)
      wb_rsp_i.ack |-> wb_req_o.cyc
   ) else $error("Wishbone ack outside a cycle");

   // Master must not disturb an open cycle before its ack.
   req_stable_a : assert property (
      @(posedge clk_i) disable iff (reset_i)
      (wb_req_o.cyc && !wb_rsp_i.ack) |=> $stable(wb_req_o)
   ) else $error("Wishbone request changed during cycle");

endmodule

// ==== wb_ram_slave.sv ====
`timescale 1ns/1ps

`include "iob_wb_macros.svh"

module wb_ram_slave (
   input  logic                clk_i,
   input  logic                reset_i,
   input  iob_wb_pkg::wb_req_t wb_req_i,
   output iob_wb_pkg::wb_rsp_t wb_rsp_o
);
   import iob_wb_pkg::*;

   localparam int DATA_W = `IOB_WB_DATA_W;
   localparam int STRB_W = DATA_W / 8;
   localparam int OFF_W  = $clog2(STRB_W);
   localparam int WORDS  = `IOB_WB_RAM_WORDS;
   localparam int IDX_W  = $clog2(WORDS);
   localparam int WAIT   = `IOB_WB_WAIT;
   localparam int CNT_W  = $clog2(WAIT + 2);

   logic [DATA_W-1:0] mem_q [WORDS];
   logic [IDX_W-1:0]  idx;
   logic [CNT_W-1:0]  cnt_q;
   logic              req_on;
   logic              ack_set;
   wb_rsp_t           rsp_q;

   assign idx      = wb_req_i.addr[IDX_W+OFF_W-1:OFF_W];  // Word index.
   assign req_on   = wb_req_i.cyc && wb_req_i.stb;        // Strobed cycle.
   assign ack_set  = req_on && !rsp_q.ack && (cnt_q == CNT_W'(WAIT));
   assign wb_rsp_o = rsp_q;

   ////////////////////////////////////////
   // Wait states and ack
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         cnt_q     <= '0;
         rsp_q.ack <= 1'b0;
      end else if (!req_on || rsp_q.ack) begin
         cnt_q     <= '0;  // Restart for next cycle.
         rsp_q.ack <= 1'b0;
      end else if (ack_set) begin
         cnt_q     <= '0;
         rsp_q.ack <= 1'b1;
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
      // Word is ready while ack is high.
      if (ack_set) begin
         rsp_q.data <= mem_q[idx];
      end
   end

   ////////////////////////////////////////
   // Storage
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < WORDS; i++) begin
            mem_q[i] <= '0;
         end
      end else if (rsp_q.ack && req_on && wb_req_i.we) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (wb_req_i.sel[b]) begin
               mem_q[idx][8*b +: 8] <= wb_req_i.data[8*b +: 8];
            end
         end
      end
   end

   // No second ack before a full wait.
   single_ack_a : assert property (
      @(posedge clk_i) disable iff (reset_i)
      wb_rsp_o.ack |-> !$past(wb_rsp_o.ack) && !$past(wb_rsp_o.ack, WAIT + 1)
   ) else $error("ack repeated without a full wait");

endmodule

// ==== iob_wb_top.sv ====
`timescale 1ns/1ps

`include "iob_wb_macros.svh"

module iob_wb_top (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic                      cmd_valid_i,
   input  iob_wb_pkg::iob_req_t      cmd_i,
   output logic                      rsp_valid_o,
   output logic [`IOB_WB_DATA_W-1:0] rsp_rdata_o,
   output logic                      overflow_o
);
   import iob_wb_pkg::*;

   logic     iob_avalid;
   iob_req_t iob_req;
   iob_rsp_t iob_rsp;
   wb_req_t  wb_req;
   wb_rsp_t  wb_rsp;

   iob_cmd_issuer issuer_i (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .cmd_valid_i (cmd_valid_i),
      .cmd_i       (cmd_i),
      .iob_ready_i (iob_rsp.ready),
      .iob_avalid_o(iob_avalid),
      .iob_req_o   (iob_req),
      .overflow_o  (overflow_o)
   );

   iob_iob2wishbone bridge_i (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .iob_avalid_i(iob_avalid),
      .iob_req_i   (iob_req),
      .iob_rsp_o   (iob_rsp),
      .wb_req_o    (wb_req),
      .wb_rsp_i    (wb_rsp)
   );

   wb_ram_slave ram_i (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .wb_req_i(wb_req),
      .wb_rsp_o(wb_rsp)
   );

   assign rsp_valid_o = iob_rsp.rvalid;  // Read responses only.
   assign rsp_rdata_o = iob_rsp.rdata;

endmodule

// ==== tb_iob_wb_top.sv ====
`timescale 1ns/1ps

`include "iob_wb_macros.svh"

module tb_iob_wb_top;
   import iob_wb_pkg::*;

   localparam int ADDR_W  = `IOB_WB_ADDR_W;
   localparam int DATA_W  = `IOB_WB_DATA_W;
   localparam int STRB_W  = DATA_W / 8;
   localparam int TIMEOUT = 50;  // Cycles per response.
   localparam int GAP     = 6;
   localparam int QUIET   = 20;

   logic              clk;
   logic              reset;
   logic              cmd_valid;
   iob_req_t          cmd;
   logic              rsp_valid;
   logic [DATA_W-1:0] rsp_rdata;
   logic              overflow;

   // Stimulus table, one entry per line.
   string             name_tab [$];
   string             op_tab   [$];
   logic [ADDR_W-1:0] addr_tab [$];
   logic [DATA_W-1:0] data_tab [$];
   logic [STRB_W-1:0] strb_tab [$];
   logic [DATA_W-1:0] want_tab [$];

   logic [DATA_W-1:0] got_q [$];
   logic [DATA_W-1:0] exp_q [$];
   logic [7:0]        model_bytes [1024];  // Byte view of the RAM.

   string cur_test;
   int    errors;
   int    test_errors;
   int    checks;
   int    tests_run;
   int    tests_failed;
   bit    ovf_expected;
   bit    abort;

   iob_wb_top dut_i (
      .clk_i      (clk),
      .reset_i    (reset),
      .cmd_valid_i(cmd_valid),
      .cmd_i      (cmd),
      .rsp_valid_o(rsp_valid),
      .rsp_rdata_o(rsp_rdata),
      .overflow_o (overflow)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Read responses in arrival order.
   always @(posedge clk) begin
      if (!reset && rsp_valid) begin
         got_q.push_back(rsp_rdata);
      end
   end

   initial begin
      repeat (20000) @(posedge clk);
      $display("Simulation ran too long, stopping");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   ////////////////////////////////////////
   // Checking and reference model
   ////////////////////////////////////////

   task automatic check_value(input string test, input string item,
                              input logic [31:0] expected, input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         test_errors++;
         $display("[FAIL] %s %s expected %08h actual %08h", test, item, expected, actual);
      end
   endtask

   function automatic int byte_index(input logic [ADDR_W-1:0] addr, input int lane);
      return int'({addr[9:2], 2'(lane)});
   endfunction

   task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                              input logic [STRB_W-1:0] wstrb);
      for (int b = 0; b < STRB_W; b++) begin
         if (wstrb[b]) begin
            model_bytes[byte_index(addr, b)] = wdata[8*b +: 8];
         end
      end
   endtask

   function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
      logic [DATA_W-1:0] word;
      for (int b = 0; b < STRB_W; b++) begin
         word[8*b +: 8] = model_bytes[byte_index(addr, b)];
      end
      return word;
   endfunction

   ////////////////////////////////////////
   // Driving and waiting
   ////////////////////////////////////////

   task automatic send_command(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                               input logic [STRB_W-1:0] wstrb);
      @(posedge clk);
      #1;
      cmd.addr  = addr;
      cmd.wdata = wdata;
      cmd.wstrb = wstrb;
      cmd_valid = 1'b1;
   endtask

   task automatic release_command();
      @(posedge clk);
      #1;
      cmd_valid = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic wait_response(output bit ok);
      int cycles;
      cycles = 0;
      while (got_q.size() == 0 && cycles < TIMEOUT) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      ok = (got_q.size() != 0);
      if (!ok) begin
         $display("Timeout in test %s, no read response within %0d cycles", cur_test, TIMEOUT);
         errors++;
         test_errors++;
         abort = 1'b1;
      end
   endtask

   task automatic drain_responses();
      bit ok;
      while (exp_q.size() > 0 && !abort) begin
         wait_response(ok);
         if (ok) begin
            check_value(cur_test, "read data", exp_q.pop_front(), got_q.pop_front());
         end
      end
   endtask

   task automatic quiet_check();
      idle_cycles(QUIET);
      check_value(cur_test, "responses after write", 0, got_q.size());
      got_q.delete();
   endtask

   ////////////////////////////////////////
   // Stimulus file and test flow
   ////////////////////////////////////////

   task automatic load_stim();
      int                fd;
      int                fields;
      string             line;
      string             nm;
      string             op;
      logic [ADDR_W-1:0] a;
      logic [DATA_W-1:0] d;
      logic [STRB_W-1:0] s;
      logic [DATA_W-1:0] w;
      fd = $fopen("iob_wb_stim.txt", "r");
      if (fd == 0) begin
         $display("Cannot open stimulus file iob_wb_stim.txt");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
               fields = $sscanf(line, "%s %s %h %h %h %h", nm, op, a, d, s, w);
               if (fields == 6) begin
                  name_tab.push_back(nm);
                  op_tab.push_back(op);
                  addr_tab.push_back(a);
                  data_tab.push_back(d);
                  strb_tab.push_back(s);
                  want_tab.push_back(w);
               end else begin
                  $display("Malformed stimulus line: %s", line);
                  errors++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic run_line(input int i);
      string             op;
      bit                is_read;
      bit                back_to_back;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
      op           = op_tab[i];
      is_read      = (op == "RD" || op == "BRD" || op == "QRD");
      back_to_back = (op.getc(0) == "B" || op.getc(0) == "Q");
      wdata        = (op == "BWR") ? DATA_W'($urandom) : data_tab[i];
      wstrb        = is_read ? '0 : strb_tab[i];
      send_command(addr_tab[i], wdata, wstrb);
      if (is_read) begin
         exp_q.push_back((op == "BRD") ? model_read(addr_tab[i]) : want_tab[i]);
      end else if (op == "QFL") begin
         ovf_expected = 1'b1;  // Flood past the queue depth.
      end else begin
         model_write(addr_tab[i], wdata, wstrb);
      end
      if (!back_to_back) begin
         release_command();
         if (op == "NWR") begin
            quiet_check();
         end else if (is_read) begin
            drain_responses();
         end
         idle_cycles(GAP);
      end
   endtask

   task automatic finish_test();
      release_command();
      drain_responses();
      check_value(cur_test, "extra responses", 0, got_q.size());
      got_q.delete();
      check_value(cur_test, "overflow flag", {31'b0, ovf_expected}, {31'b0, overflow});
      tests_run++;
      if (test_errors != 0) begin
         tests_failed++;
      end
      $display("test %s: %s", cur_test, (test_errors == 0) ? "passed" : "failed");
      idle_cycles(GAP);
   endtask

   initial begin
      int n;
      void'($urandom(32'h971b));
      reset        = 1'b1;
      cmd_valid    = 1'b0;
      cmd          = '0;
      errors       = 0;
      test_errors  = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      ovf_expected = 1'b0;
      abort        = 1'b0;
      for (int k = 0; k < 1024; k++) begin
         model_bytes[k] = '0;  // RAM clears on reset.
      end
      load_stim();
      n = name_tab.size();
      if (n == 0) begin
         $display("No stimulus lines were read");
         errors++;
      end
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      idle_cycles(2);
      for (int i = 0; i < n && !abort; i++) begin
         if (i == 0 || name_tab[i] != name_tab[i-1]) begin
            cur_test    = name_tab[i];
            test_errors = 0;
         end
         run_line(i);
         if (i == n - 1 || name_tab[i+1] != name_tab[i]) begin
            finish_test();
         end
      end
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== iob_wb_stim.txt ====
# name op addr wdata wstrb expect, all hex, reads carry wstrb 0
# WR/RD spaced, NWR write with no response, BWR/BRD burst with random data, QWR/QRD/QFL flood
full_word      WR  00000010 deadbeef f deadbeef
full_word      RD  00000010 00000000 0 deadbeef
full_word      WR  00000014 12345678 f 12345678
full_word      RD  00000014 00000000 0 12345678
full_word      WR  000003fc a5a55a5a f a5a55a5a
full_word      RD  000003fc 00000000 0 a5a55a5a
full_word      RD  00000010 00000000 0 deadbeef
full_word      RD  00000018 00000000 0 00000000
byte_strobe    WR  00000020 11223344 f 11223344
byte_strobe    WR  00000020 aabbccdd 1 112233dd
byte_strobe    RD  00000020 00000000 0 112233dd
byte_strobe    WR  00000020 eeff0099 6 11ff00dd
byte_strobe    RD  00000020 00000000 0 11ff00dd
byte_strobe    WR  00000020 77000000 8 77ff00dd
byte_strobe    RD  00000020 00000000 0 77ff00dd
byte_strobe    WR  00000024 cafef00d 3 0000f00d
byte_strobe    RD  00000024 00000000 0 0000f00d
unaligned      WR  00000030 01020304 f 01020304
unaligned      RD  00000031 00000000 0 01020304
unaligned      RD  00000032 00000000 0 01020304
unaligned      RD  00000033 00000000 0 01020304
burst_a        BWR 00000040 00000000 f 00000000
burst_a        BWR 00000044 00000000 f 00000000
burst_a        BRD 00000040 00000000 0 00000000
burst_a        BRD 00000044 00000000 0 00000000
burst_b        BWR 00000048 00000000 f 00000000
burst_b        BWR 00000048 00000000 5 00000000
burst_b        BRD 00000048 00000000 0 00000000
burst_b        BRD 00000040 00000000 0 00000000
no_response    NWR 00000050 13572468 f 13572468
no_response    RD  00000050 00000000 0 13572468
no_response    NWR 00000050 ffff0000 c ffff2468
no_response    RD  00000050 00000000 0 ffff2468
queue_overflow QWR 00000060 0badf00d f 0badf00d
queue_overflow QWR 00000064 feedface f feedface
queue_overflow QRD 00000060 00000000 0 0badf00d
queue_overflow QRD 00000064 00000000 0 feedface
queue_overflow QFL 00000070 00000000 f 00000000
queue_overflow QFL 00000070 00000000 f 00000000
queue_overflow QFL 00000070 00000000 f 00000000
queue_overflow QFL 00000070 00000000 f 00000000
after_overflow RD  00000060 00000000 0 0badf00d

// ==== filelist.f ====
+incdir+.
iob_wb_pkg.sv
iob_cmd_issuer.sv
iob_iob2wishbone.sv
wb_ram_slave.sv
iob_wb_top.sv
tb_iob_wb_top.sv

// ==== Makefile ====
# Verilator flow for the IOb to Wishbone subsystem.

TOP = tb_iob_wb_top
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
